// File: common/game_pkg.sv
package game_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [10:0] tile_addr_t;
    typedef logic [11:0] score_t;
    typedef logic [2:0]  lives_t;

    typedef enum logic [3:0]
    {
        tile_empty  = 4'd0,
        tile_wall   = 4'd1,
        tile_pellet = 4'd2,
        tile_chase  = 4'd5,
        tile_freeze = 4'd7,
        tile_big    = 4'd11
    } tile_t;

    typedef enum logic [1:0]
    {
        dir_left  = 2'd0,
        dir_right = 2'd1,
        dir_down  = 2'd2,
        dir_up    = 2'd3
    } dir_t;

    // Keyboard usage codes
    localparam logic [7:0] key_a     = 8'h04;
    localparam logic [7:0] key_d     = 8'h07;
    localparam logic [7:0] key_s     = 8'h16;
    localparam logic [7:0] key_w     = 8'h1A;
    localparam logic [7:0] key_up    = 8'h52;
    localparam logic [7:0] key_down  = 8'h51;
    localparam logic [7:0] key_left  = 8'h50;
    localparam logic [7:0] key_right = 8'h4F;

    localparam int map_cols   = 40;
    localparam int map_tiles  = 1200;
    localparam int tile_shift = 4;   // 16 pixel tiles

    localparam coord_t probe_ahead  = 10'd9;
    localparam coord_t probe_side   = 10'd5;
    localparam coord_t contact_dist = 10'd12;
    localparam score_t score_pellet = 12'd5;
    localparam score_t score_big    = 12'd50;
    localparam lives_t lives_start  = 3'd3;

    function automatic tile_addr_t tile_addr(input coord_t x, input coord_t y);
        tile_addr_t col;
        tile_addr_t row;
        col = tile_addr_t'(x >> tile_shift);
        row = tile_addr_t'(y >> tile_shift);
        return col + row * tile_addr_t'(map_cols);
    endfunction

endpackage

// File: common/tile_probe_if.sv
interface tile_probe_if;
    game_pkg::tile_addr_t addr_a;
    game_pkg::tile_addr_t addr_b;
    game_pkg::tile_t      tile_a;
    game_pkg::tile_t      tile_b;

    modport mover (output addr_a, addr_b, input tile_a, tile_b);
    modport map   (input addr_a, addr_b, output tile_a, tile_b);
endinterface

interface tile_eat_if;
    game_pkg::tile_addr_t center_addr;
    game_pkg::tile_t      center_tile;
    logic                 clear_en;
    game_pkg::tile_addr_t clear_addr;

    modport eater (output center_addr, clear_en, clear_addr, input center_tile);
    modport map   (input center_addr, clear_en, clear_addr, output center_tile);
endinterface

// File: src/tile_map.sv
module tile_map
(
    input  logic                 Reset,
    input  logic                 frame_clk,
    input  logic                 map_load_en,
    input  game_pkg::tile_addr_t map_load_addr,
    input  game_pkg::tile_t      map_load_tile,
    tile_probe_if.map            pac_probe,
    tile_probe_if.map            ghost_probe,
    tile_eat_if.map              eat
);

    game_pkg::tile_t mem [game_pkg::map_tiles];

    // Anything off the map reads as wall
    function automatic game_pkg::tile_t rd(input game_pkg::tile_addr_t addr);
        if (addr < game_pkg::map_tiles)
            return mem[addr];
        else
            return game_pkg::tile_wall;
    endfunction

    always_comb
    begin
        pac_probe.tile_a   = rd(pac_probe.addr_a);
        pac_probe.tile_b   = rd(pac_probe.addr_b);
        ghost_probe.tile_a = rd(ghost_probe.addr_a);
        ghost_probe.tile_b = rd(ghost_probe.addr_b);
        eat.center_tile    = rd(eat.center_addr);
    end

    always_ff @(posedge Reset)
    begin
        if (map_load_en)
        begin
            mem[map_load_addr] <= map_load_tile;
        end
        else if (eat.clear_en && !frame_clk)  // Hold the map while in reset
        begin
            mem[eat.clear_addr] <= game_pkg::tile_empty;
        end
    end

endmodule

// File: pacman/pacman_mover.sv
module pacman_mover #(
    parameter game_pkg::coord_t PAC_HOME_X = 10'd264,
    parameter game_pkg::coord_t PAC_HOME_Y = 10'd264
)
(
    input  logic             Reset,
    input  logic             frame_clk,
    input  logic [7:0]       keycode_pacman,
    tile_probe_if.mover      probe,
    input  logic             respawn,
    input  logic             hold,
    output game_pkg::coord_t pac_x,
    output game_pkg::coord_t pac_y,
    output game_pkg::dir_t   pac_dir
);

    logic [7:0]       key_q;
    logic             key_valid;
    game_pkg::dir_t   key_dir;
    game_pkg::coord_t ax, ay;
    game_pkg::coord_t bx, by;
    logic             way_clear;

    always_comb
    begin
        key_valid = 1'b1;
        key_dir   = pac_dir;
        case (key_q)
            game_pkg::key_a: key_dir = game_pkg::dir_left;
            game_pkg::key_d: key_dir = game_pkg::dir_right;
            game_pkg::key_s: key_dir = game_pkg::dir_down;
            game_pkg::key_w: key_dir = game_pkg::dir_up;
            default:         key_valid = 1'b0;
        endcase
    end

    // Two points ahead, one each side of the centre line
    always_comb
    begin
        ax = pac_x;
        bx = pac_x;
        ay = pac_y;
        by = pac_y;
        case (key_dir)
            game_pkg::dir_left:
            begin
                ax = pac_x - game_pkg::probe_ahead;
                bx = ax;
                ay = pac_y - game_pkg::probe_side;
                by = pac_y + game_pkg::probe_side;
            end
            game_pkg::dir_right:
            begin
                ax = pac_x + game_pkg::probe_ahead;
                bx = ax;
                ay = pac_y - game_pkg::probe_side;
                by = pac_y + game_pkg::probe_side;
            end
            game_pkg::dir_down:
            begin
                ax = pac_x + game_pkg::probe_side;
                bx = pac_x - game_pkg::probe_side;
                ay = pac_y + game_pkg::probe_ahead;
                by = ay;
            end
            game_pkg::dir_up:
            begin
                ax = pac_x + game_pkg::probe_side;
                bx = pac_x - game_pkg::probe_side;
                ay = pac_y - game_pkg::probe_ahead;
                by = ay;
            end
        endcase
    end

    assign probe.addr_a = game_pkg::tile_addr(ax, ay);
    assign probe.addr_b = game_pkg::tile_addr(bx, by);
    assign way_clear    = (probe.tile_a != game_pkg::tile_wall) &&
                          (probe.tile_b != game_pkg::tile_wall);

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            key_q   <= 8'h00;
            pac_x   <= PAC_HOME_X;
            pac_y   <= PAC_HOME_Y;
            pac_dir <= game_pkg::dir_left;
        end
        else
        begin
            key_q <= keycode_pacman;
            if (respawn)
            begin
                pac_x <= PAC_HOME_X;
                pac_y <= PAC_HOME_Y;
            end
            else if (!hold && key_valid)
            begin
                pac_dir <= key_dir;
                if (way_clear)
                begin
                    case (key_dir)
                        game_pkg::dir_left:  pac_x <= pac_x - 10'd1;
                        game_pkg::dir_right: pac_x <= pac_x + 10'd1;
                        game_pkg::dir_down:  pac_y <= pac_y + 10'd1;
                        game_pkg::dir_up:    pac_y <= pac_y - 10'd1;
                    endcase
                end
            end
        end
    end

endmodule

// File: pacman/pellet_eater.sv
module pellet_eater #(
    parameter logic [8:0] FOOD_TO_WIN = 9'd200
)
(
    input  logic             Reset,
    input  logic             frame_clk,
    input  game_pkg::coord_t pac_x,
    input  game_pkg::coord_t pac_y,
    tile_eat_if.eater        eat,
    output game_pkg::score_t score,
    output logic             win,
    output logic             freeze_hit,
    output logic             chase_hit
);

    logic [8:0] food_count;
    logic       small_hit;
    logic       big_hit;

    // Tile under the sprite centre
    assign eat.center_addr = game_pkg::tile_addr(pac_x, pac_y);

    assign small_hit  = (eat.center_tile == game_pkg::tile_pellet);
    assign big_hit    = (eat.center_tile == game_pkg::tile_big);
    assign freeze_hit = (eat.center_tile == game_pkg::tile_freeze);
    assign chase_hit  = (eat.center_tile == game_pkg::tile_chase);

    // Power-up tiles are used up too
    assign eat.clear_en   = small_hit | big_hit | freeze_hit | chase_hit;
    assign eat.clear_addr = eat.center_addr;

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            score      <= '0;
            food_count <= '0;
            win        <= 1'b0;
        end
        else
        begin
            if (small_hit)
            begin
                score      <= score + game_pkg::score_pellet;
                food_count <= food_count + 9'd1;
            end
            else if (big_hit)
            begin
                score      <= score + game_pkg::score_big;
                food_count <= food_count + 9'd1;
            end
            // Sticky once reached
            win <= win | (food_count >= FOOD_TO_WIN);
        end
    end

endmodule

// File: src/ghost_mover.sv
module ghost_mover #(
    parameter game_pkg::coord_t GHOST_HOME_X = 10'd248,
    parameter game_pkg::coord_t GHOST_HOME_Y = 10'd208
)
(
    input  logic             Reset,
    input  logic             frame_clk,
    input  logic [7:0]       keycode_ghost,
    tile_probe_if.mover      probe,
    input  logic             respawn,
    input  logic             hold,
    input  logic             freeze,
    output game_pkg::coord_t ghost_x,
    output game_pkg::coord_t ghost_y
);

    logic [7:0]       key_q;
    logic             key_valid;
    game_pkg::coord_t nx, ny;   // Position after one step
    game_pkg::coord_t ax, ay;
    game_pkg::coord_t bx, by;

    // Arrow keys give the step and the probe points
    always_comb
    begin
        key_valid = 1'b1;
        nx = ghost_x;
        ny = ghost_y;
        ax = ghost_x + game_pkg::probe_side;
        bx = ghost_x - game_pkg::probe_side;
        ay = ghost_y - game_pkg::probe_ahead;
        by = ay;
        case (key_q)
            game_pkg::key_up:    ny = ghost_y - 10'd1;
            game_pkg::key_down:
            begin
                ny = ghost_y + 10'd1;
                ay = ghost_y + game_pkg::probe_ahead;
                by = ay;
            end
            game_pkg::key_left, game_pkg::key_right:
            begin
                nx = (key_q == game_pkg::key_left) ? ghost_x - 10'd1 : ghost_x + 10'd1;
                ax = (key_q == game_pkg::key_left) ? ghost_x - game_pkg::probe_ahead
                                                   : ghost_x + game_pkg::probe_ahead;
                bx = ax;
                ay = ghost_y - game_pkg::probe_side;
                by = ghost_y + game_pkg::probe_side;
            end
            default: key_valid = 1'b0;
        endcase
    end

    assign probe.addr_a = game_pkg::tile_addr(ax, ay);
    assign probe.addr_b = game_pkg::tile_addr(bx, by);

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            key_q   <= 8'h00;
            ghost_x <= GHOST_HOME_X;
            ghost_y <= GHOST_HOME_Y;
        end
        else
        begin
            key_q <= keycode_ghost;
            if (respawn)
            begin
                ghost_x <= GHOST_HOME_X;
                ghost_y <= GHOST_HOME_Y;
            end
            else if (!hold && !freeze && key_valid &&
                     probe.tile_a != game_pkg::tile_wall &&
                     probe.tile_b != game_pkg::tile_wall)
            begin
                ghost_x <= nx;
                ghost_y <= ny;
            end
        end
    end

endmodule

// File: src/game_control.sv
module game_control #(
    parameter logic [8:0] POWER_FRAMES = 9'd350
)
(
    input  logic             Reset,
    input  logic             frame_clk,
    input  game_pkg::coord_t pac_x,
    input  game_pkg::coord_t pac_y,
    input  game_pkg::coord_t ghost_x,
    input  game_pkg::coord_t ghost_y,
    input  logic             freeze_hit,
    input  logic             chase_hit,
    output logic             pac_respawn,
    output logic             ghost_respawn,
    output game_pkg::lives_t lives,
    output logic             loss,
    output logic             freeze_on,
    output logic             chase_on
);

    game_pkg::coord_t dx;
    game_pkg::coord_t dy;
    logic             contact;
    logic [8:0]       power_cnt;

    assign dx = (pac_x >= ghost_x) ? pac_x - ghost_x : ghost_x - pac_x;
    assign dy = (pac_y >= ghost_y) ? pac_y - ghost_y : ghost_y - pac_y;
    assign contact = (dx <= game_pkg::contact_dist) && (dy <= game_pkg::contact_dist);

    // Chase mode decides who goes home
    assign pac_respawn   = contact && !chase_on && !loss;
    assign ghost_respawn = contact && chase_on && !loss;

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            lives <= game_pkg::lives_start;
            loss  <= 1'b0;
        end
        else if (pac_respawn)
        begin
            lives <= lives - 3'd1;
            if (lives == 3'd1)
                loss <= 1'b1;   // Last life gone
        end
    end

    // Shared timer; a new hit restarts it
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            power_cnt <= '0;
            freeze_on <= 1'b0;
            chase_on  <= 1'b0;
        end
        else if (freeze_hit)
        begin
            power_cnt <= POWER_FRAMES - 9'd1;
            freeze_on <= 1'b1;
            chase_on  <= 1'b0;
        end
        else if (chase_hit)
        begin
            power_cnt <= POWER_FRAMES - 9'd1;
            freeze_on <= 1'b0;
            chase_on  <= 1'b1;
        end
        else if (power_cnt != 9'd0)
        begin
            power_cnt <= power_cnt - 9'd1;
        end
        else
        begin
            freeze_on <= 1'b0;
            chase_on  <= 1'b0;
        end
    end

endmodule

// File: src/pacman_game.sv
module pacman_game #(
    parameter game_pkg::coord_t PAC_HOME_X   = 10'd264,
    parameter game_pkg::coord_t PAC_HOME_Y   = 10'd264,
    parameter game_pkg::coord_t GHOST_HOME_X = 10'd248,
    parameter game_pkg::coord_t GHOST_HOME_Y = 10'd208,
    parameter logic [8:0]       FOOD_TO_WIN  = 9'd200,
    parameter logic [8:0]       POWER_FRAMES = 9'd350
)
(
    input  logic                 Reset,
    input  logic                 frame_clk,
    input  logic [7:0]           keycode_pacman,
    input  logic [7:0]           keycode_ghost,
    input  logic                 map_load_en,
    input  game_pkg::tile_addr_t map_load_addr,
    input  game_pkg::tile_t      map_load_tile,
    output game_pkg::coord_t     pac_x,
    output game_pkg::coord_t     pac_y,
    output game_pkg::dir_t       pac_dir,
    output game_pkg::coord_t     ghost_x,
    output game_pkg::coord_t     ghost_y,
    output game_pkg::score_t     score,
    output game_pkg::lives_t     lives,
    output logic                 win,
    output logic                 loss,
    output logic                 freeze_on,
    output logic                 chase_on
);

    logic freeze_hit;
    logic chase_hit;
    logic pac_respawn;
    logic ghost_respawn;
    logic game_hold;

    tile_probe_if pac_probe ();
    tile_probe_if ghost_probe ();
    tile_eat_if   eat ();

    assign game_hold = win | loss;

    tile_map map_i (.Reset, .frame_clk, .map_load_en, .map_load_addr, .map_load_tile,
                    .pac_probe(pac_probe.map), .ghost_probe(ghost_probe.map),
                    .eat(eat.map));

    pacman_mover #(.PAC_HOME_X(PAC_HOME_X), .PAC_HOME_Y(PAC_HOME_Y)) pac_i (
        .Reset, .frame_clk, .keycode_pacman, .probe(pac_probe.mover),
        .respawn(pac_respawn), .hold(game_hold), .pac_x, .pac_y, .pac_dir);

    pellet_eater #(.FOOD_TO_WIN(FOOD_TO_WIN)) eater_i (
        .Reset, .frame_clk, .pac_x, .pac_y, .eat(eat.eater), .score, .win,
        .freeze_hit, .chase_hit);

    ghost_mover #(.GHOST_HOME_X(GHOST_HOME_X), .GHOST_HOME_Y(GHOST_HOME_Y)) ghost_i (
        .Reset, .frame_clk, .keycode_ghost, .probe(ghost_probe.mover),
        .respawn(ghost_respawn), .hold(game_hold), .freeze(freeze_on),
        .ghost_x, .ghost_y);

    game_control #(.POWER_FRAMES(POWER_FRAMES)) ctrl_i (
        .Reset, .frame_clk, .pac_x, .pac_y, .ghost_x, .ghost_y, .freeze_hit, .chase_hit,
        .pac_respawn, .ghost_respawn, .lives, .loss, .freeze_on, .chase_on);

endmodule

// File: bench/tb_pacman_game.sv
module tb_pacman_game;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int pac_home_x   = 264;
    localparam int pac_home_y   = 264;
    localparam int ghost_home_x = 248;
    localparam int ghost_home_y = 208;
    localparam int tile_px      = 16;
    localparam int ahead_px     = 9;
    localparam int cols         = 40;
    localparam int rows         = 30;
    localparam int small_pts    = 5;
    localparam int big_pts      = 50;
    localparam int power_len    = 20;
    localparam logic [7:0] key_other = 8'h55;

    // Outputs that wait_for can watch
    localparam int sel_pac_x   = 0;
    localparam int sel_ghost_y = 1;
    localparam int sel_lives   = 2;
    localparam int sel_win     = 3;
    localparam int sel_loss    = 4;
    localparam int sel_freeze  = 5;
    localparam int sel_chase   = 6;

    logic                 Reset;
    logic                 frame_clk;
    logic [7:0]           keycode_pacman;
    logic [7:0]           keycode_ghost;
    logic                 map_load_en;
    game_pkg::tile_addr_t map_load_addr;
    game_pkg::tile_t      map_load_tile;
    logic [9:0]           pac_x;
    logic [9:0]           pac_y;
    logic [1:0]           pac_dir;
    logic [9:0]           ghost_x;
    logic [9:0]           ghost_y;
    logic [11:0]          score;
    logic [2:0]           lives;
    logic                 win;
    logic                 loss;
    logic                 freeze_on;
    logic                 chase_on;

    int checks;
    int errors;
    int timeouts;
    int seed = 58;

    pacman_game #(.FOOD_TO_WIN(9'd3), .POWER_FRAMES(9'd20)) dut_i (
        .Reset, .frame_clk, .keycode_pacman, .keycode_ghost, .map_load_en, .map_load_addr,
        .map_load_tile, .pac_x, .pac_y, .pac_dir, .ghost_x, .ghost_y, .score, .lives,
        .win, .loss, .freeze_on, .chase_on);

    initial
    begin
        Reset = 1'b0;
        forever #5 Reset = ~Reset;
    end

    initial
    begin
        #1ms;
        $display("Simulation did not finish in time");
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error: %s is %0h, expected %0h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] read_output(input int sel);
        logic [31:0] v;
        case (sel)
            sel_pac_x:   v = 32'(pac_x);
            sel_ghost_y: v = 32'(ghost_y);
            sel_lives:   v = 32'(lives);
            sel_win:     v = 32'(win);
            sel_loss:    v = 32'(loss);
            sel_freeze:  v = 32'(freeze_on);
            sel_chase:   v = 32'(chase_on);
            default:     v = '0;
        endcase
        return v;
    endfunction

    task automatic wait_for(input string name, input int sel, input int value, input int limit);
        int n;
        n = 0;
        while (read_output(sel) !== 32'(value) && n < limit)
        begin
            @(negedge Reset);
            n++;
        end
        if (read_output(sel) !== 32'(value))
        begin
            timeouts++;
            $display("Timed out after %0d frames waiting for %s to reach %0h", limit, name, value);
        end
    endtask

    function automatic bit is_border(input int a);
        int col;
        int row;
        col = a % cols;
        row = a / cols;
        return (col == 0) || (col == cols - 1) || (row == 0) || (row == rows - 1);
    endfunction

    // Walls round the edge, open floor inside
    task automatic load_map;
        int a;
        @(posedge Reset);
        frame_clk      <= 1'b1;   // Game parked while the map is written
        keycode_pacman <= 8'h00;
        keycode_ghost  <= 8'h00;
        for (a = 0; a < cols * rows; a++)
        begin
            map_load_en   <= 1'b1;
            map_load_addr <= game_pkg::tile_addr_t'(a);
            if (is_border(a))
                map_load_tile <= game_pkg::tile_wall;
            else
                map_load_tile <= game_pkg::tile_empty;
            @(posedge Reset);
        end
        map_load_en <= 1'b0;
    endtask

    task automatic put_tile(input int col, input int row, input game_pkg::tile_t t);
        @(posedge Reset);
        map_load_en   <= 1'b1;
        map_load_addr <= game_pkg::tile_addr_t'(col + row * cols);
        map_load_tile <= t;
        @(posedge Reset);
        map_load_en <= 1'b0;
    endtask

    task automatic start_game;
        @(posedge Reset);
        frame_clk      <= 1'b1;
        keycode_pacman <= 8'h00;
        keycode_ghost  <= 8'h00;
        repeat (4) @(posedge Reset);
        frame_clk <= 1'b0;
        @(negedge Reset);
    endtask

    task automatic set_keys(input logic [7:0] pk, input logic [7:0] gk);
        @(posedge Reset);
        keycode_pacman <= pk;
        keycode_ghost  <= gk;
        @(negedge Reset);
    endtask

    task automatic run_frames(input int n);
        repeat (n) @(negedge Reset);
    endtask

    // Latched key still gives two more steps
    task automatic release_keys;
        set_keys(8'h00, 8'h00);
        run_frames(2);
    endtask

    task automatic reset_and_walls;
        int wall_col;
        wall_col = pac_home_x / tile_px + 2;
        load_map();
        put_tile(wall_col, pac_home_y / tile_px, game_pkg::tile_wall);
        start_game();
        check_value("pac_x", pac_x, pac_home_x);
        check_value("pac_y", pac_y, pac_home_y);
        check_value("pac_dir", pac_dir, 0);
        check_value("ghost_x", ghost_x, ghost_home_x);
        check_value("ghost_y", ghost_y, ghost_home_y);
        check_value("lives", lives, 3);
        check_value("score", score, 0);
        check_value("win", win, 0);
        check_value("loss", loss, 0);
        check_value("freeze_on", freeze_on, 0);
        check_value("chase_on", chase_on, 0);
        set_keys(game_pkg::key_d, 8'h00);
        wait_for("pac_x", sel_pac_x, wall_col * tile_px - ahead_px, 40);
        run_frames(5);
        check_value("pac_x", pac_x, wall_col * tile_px - ahead_px);   // Probe tip at wall edge
        release_keys();
    endtask

    task automatic steering;
        int start_x;
        int start_y;
        load_map();
        start_game();
        set_keys(game_pkg::key_d, 8'h00);
        run_frames(10);
        check_value("pac_x", pac_x, pac_home_x + 9);
        check_value("pac_dir", pac_dir, 1);
        release_keys();
        start_x = pac_x;
        set_keys(key_other, 8'h00);
        run_frames(6);
        check_value("pac_x", pac_x, start_x);
        check_value("pac_dir", pac_dir, 1);
        release_keys();
        set_keys(game_pkg::key_s, 8'h00);
        run_frames(4);
        check_value("pac_y", pac_y, pac_home_y + 3);
        check_value("pac_dir", pac_dir, 2);
        release_keys();
        start_y = ghost_y;
        set_keys(8'h00, game_pkg::key_down);
        run_frames(8);
        check_value("ghost_y", ghost_y, start_y + 7);
        release_keys();
        start_y = ghost_y;
        set_keys(8'h00, game_pkg::key_up);
        run_frames(6);
        check_value("ghost_y", ghost_y, start_y - 5);
        check_value("ghost_x", ghost_x, ghost_home_x);
        release_keys();
    endtask

    task automatic pellets_and_win;
        int big_slot;
        int hold_x;
        big_slot = ($random(seed) & 32'h7fff_ffff) % 3;
        load_map();
        for (int i = 0; i < 3; i++)
        begin
            if (i == big_slot)
                put_tile(pac_home_x / tile_px + 1 + i, pac_home_y / tile_px, game_pkg::tile_big);
            else
                put_tile(pac_home_x / tile_px + 1 + i, pac_home_y / tile_px,
                         game_pkg::tile_pellet);
        end
        start_game();
        set_keys(game_pkg::key_d, 8'h00);
        wait_for("win", sel_win, 1, 80);
        check_value("score", score, 2 * small_pts + big_pts);
        hold_x = pac_x;
        run_frames(10);
        check_value("pac_x", pac_x, hold_x);   // Frozen after the win
        release_keys();
    endtask

    task automatic contact_and_loss;
        int ghost_hold;
        load_map();
        start_game();
        // Pac-Man steps left into the ghost's column range
        set_keys(game_pkg::key_a, 8'h00);
        run_frames(5);
        release_keys();
        check_value("pac_dir", pac_dir, 0);
        set_keys(8'h00, game_pkg::key_down);
        wait_for("lives", sel_lives, 2, 80);
        check_value("pac_x", pac_x, pac_home_x);
        check_value("pac_y", pac_y, pac_home_y);
        check_value("ghost_x", ghost_x, ghost_home_x);
        check_value("loss", loss, 0);
        release_keys();
        set_keys(game_pkg::key_a, 8'h00);
        wait_for("lives", sel_lives, 1, 40);
        check_value("pac_x", pac_x, pac_home_x);
        wait_for("loss", sel_loss, 1, 40);
        check_value("lives", lives, 0);
        check_value("pac_x", pac_x, pac_home_x);
        ghost_hold = ghost_y;
        set_keys(game_pkg::key_a, game_pkg::key_up);
        run_frames(6);
        check_value("pac_x", pac_x, pac_home_x);
        check_value("ghost_y", ghost_y, ghost_hold);
        check_value("loss", loss, 1);
        release_keys();
    endtask

    task automatic freeze_power;
        int frozen_y;
        int high;
        load_map();
        put_tile(pac_home_x / tile_px + 1, pac_home_y / tile_px, game_pkg::tile_freeze);
        start_game();
        set_keys(game_pkg::key_d, game_pkg::key_down);
        wait_for("freeze_on", sel_freeze, 1, 40);
        frozen_y = ghost_y;
        high = 0;
        while (freeze_on === 1'b1 && high < 2 * power_len)
        begin
            check_value("ghost_y", ghost_y, frozen_y);
            run_frames(1);
            high++;
        end
        check_value("freeze_on frames", high, power_len);
        check_value("chase_on", chase_on, 0);
        run_frames(2);
        check_value("ghost_y", ghost_y, frozen_y + 2);   // Moving again
        release_keys();
    endtask

    task automatic chase_power;
        int stop_x;
        load_map();
        put_tile(pac_home_x / tile_px - 1, pac_home_y / tile_px, game_pkg::tile_chase);
        start_game();
        // Ghost parked just out of reach above Pac-Man
        set_keys(8'h00, game_pkg::key_down);
        wait_for("ghost_y", sel_ghost_y, pac_home_y - 18, 60);
        release_keys();
        check_value("ghost_y", ghost_y, pac_home_y - 16);
        set_keys(game_pkg::key_a, 8'h00);
        wait_for("chase_on", sel_chase, 1, 30);
        release_keys();
        stop_x = pac_x;
        set_keys(8'h00, game_pkg::key_down);
        wait_for("ghost_y", sel_ghost_y, ghost_home_y, 30);
        check_value("ghost_x", ghost_x, ghost_home_x);
        check_value("lives", lives, 3);
        check_value("chase_on", chase_on, 1);
        check_value("pac_x", pac_x, stop_x);
        release_keys();
    endtask

    initial
    begin
        frame_clk      = 1'b1;
        keycode_pacman = 8'h00;
        keycode_ghost  = 8'h00;
        map_load_en    = 1'b0;
        map_load_addr  = '0;
        map_load_tile  = game_pkg::tile_empty;
        checks         = 0;
        errors         = 0;
        timeouts       = 0;
        reset_and_walls();
        steering();
        pellets_and_win();
        contact_and_loss();
        freeze_power();
        chase_power();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: list.f
common/game_pkg.sv
common/tile_probe_if.sv
src/tile_map.sv
pacman/pacman_mover.sv
pacman/pellet_eater.sv
src/ghost_mover.sv
src/game_control.sv
src/pacman_game.sv
bench/tb_pacman_game.sv

// File: Bender.yml
package:
  name: pacman_game

sources:
  - common/game_pkg.sv
  - common/tile_probe_if.sv
  - src/tile_map.sv
  - pacman/pacman_mover.sv
  - pacman/pellet_eater.sv
  - src/ghost_mover.sv
  - src/game_control.sv
  - src/pacman_game.sv
  - target: test
    files:
      - bench/tb_pacman_game.sv
